//--- build.f
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/byte_fifo.sv
verilog/uart_hex_logger.sv
verilog/uart_echo_top.sv
tb/uart_monitor.sv
tb/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the uart echo testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -Wno-fatal --top-module tb_top -f build.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/uart_tests.txt
# kind name opt n then n hex values; opt is the max gap in bit times for rx, cycles (hex) for gap
# an rx line with opt 0 is sent back to back and the next test starts without draining
rx echo_basic 3 3 41 42 43
rx echo_edges 3 3 00 ff 55
bad bad_stop 0 1 a5
gap idle_wait 64 0
log log_zero 0 1 0000
log log_ones 0 1 ffff
log log_a5c3 0 1 a5c3
log log_1234 0 1 1234
rx burst_20 0 20 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 01 80 7e 55
log burst_log 0 1 beef
log log_pair 0 2 a5c3 1234
bad bad_stop2 0 1 3c
rx echo_tail 3 4 de ad be ef

//--- tb/tb_top.sv
`timescale 1ns/10ps
module tb_top;
    import uart_pkg::*;

    localparam int MAX_TESTS = 32;
    localparam int MAX_VALS  = 24;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         rx;
    logic         log_valid;
    log_val_t     log_value;
    logic         log_ready;
    logic         tx;
    logic         frame_error;
    logic         push;
    byte_t        push_byte;
    logic [127:0] push_name;
    logic         expect_busy;
    int           pending;
    int           value_errs;
    int           other_errs;
    int           fe_count;

    string        t_kind [MAX_TESTS];
    logic [127:0] t_name [MAX_TESTS];
    int           t_opt  [MAX_TESTS];
    int           t_n    [MAX_TESTS];
    logic [15:0]  t_val  [MAX_TESTS][MAX_VALS];
    int           n_tests = 0;
    int           n_bad   = 0;
    int           tb_errs = 0;
    int           cycles  = 0;
    int           limit   = 32'h7fffffff;
    logic [31:0]  lfsr    = 32'h13a5e840;

    uart_echo_top dut (
        .clk(clk), .arst_n(arst_n), .rx(rx), .log_valid(log_valid),
        .log_value(log_value), .log_ready(log_ready), .tx(tx),
        .frame_error(frame_error)
    );

    uart_monitor checker_mon (
        .clk(clk), .arst_n(arst_n), .tx(tx), .frame_error(frame_error),
        .log_ready(log_ready), .expect_busy(expect_busy), .push(push),
        .push_byte(push_byte), .push_name(push_name), .pending(pending),
        .value_errs(value_errs), .other_errs(other_errs), .fe_count(fe_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d bytes never arrived", cycles, pending);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    function automatic byte_t hex_char(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return byte_t'(digits[nib]);
    endfunction

    task automatic expect_byte(input byte_t b, input logic [127:0] nm);
        push      = 1'b1;
        push_byte = b;
        push_name = nm;
        @(posedge clk);
        #1 push = 1'b0;
    endtask

    task automatic hold_bit(input logic v);
        rx = v;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input byte_t b, input logic stop);
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++)
            hold_bit(b[i]);
        hold_bit(stop);
        rx = 1'b1;
    endtask

    task automatic random_gap(input int max_bits);
        logic [1:0] g;
        if (max_bits == 0)
            return;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            g    = {g[0], lfsr[0]};
        end
        repeat (int'(g) * CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        while (pending != 0)
            @(posedge clk);
        repeat (2 * CLKS_PER_BIT) @(posedge clk); // let the stop bit finish
        #1;
    endtask

    // each following request is held valid while the previous message is sent
    task automatic send_logs(input int t);
        for (int j = 0; j < t_n[t]; j++) begin
            log_value = t_val[t][j];
            log_valid = 1'b1;
            while (log_ready !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk); // request taken on this edge
            #1;
            if (j + 1 < t_n[t])
                log_value = t_val[t][j + 1];
            else
                log_valid = 1'b0;
            expect_busy = 1'b1; // six bytes take at least six cycles
            repeat (6) @(posedge clk);
            #1 expect_busy = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        int fe_before;
        case (t_kind[t])
            "rx": begin
                for (int j = 0; j < t_n[t]; j++)
                    expect_byte(t_val[t][j][7:0], t_name[t]);
                for (int j = 0; j < t_n[t]; j++) begin
                    send_byte(t_val[t][j][7:0], 1'b1);
                    random_gap(t_opt[t]);
                end
                if (t_opt[t] != 0)
                    wait_drain();
            end
            "bad": begin
                fe_before = fe_count;
                send_byte(t_val[t][0][7:0], 1'b0);
                repeat (2 * CLKS_PER_BIT) @(posedge clk);
                #1;
                if (fe_count != fe_before + 1) begin
                    $display("%0s gave %0d frame_error pulses instead of one",
                             t_name[t], fe_count - fe_before);
                    tb_errs++;
                end
                wait_drain();
            end
            "log": begin
                for (int j = 0; j < t_n[t]; j++) begin
                    for (int k = 3; k >= 0; k--)
                        expect_byte(hex_char(t_val[t][j][k*4 +: 4]), t_name[t]);
                    expect_byte(8'h0d, t_name[t]);
                    expect_byte(8'h0a, t_name[t]);
                end
                send_logs(t);
                wait_drain();
            end
            "gap": begin
                repeat (t_opt[t]) @(posedge clk);
                #1;
            end
            default: begin
                $display("unknown test kind %0s", t_kind[t]);
                tb_errs++;
            end
        endcase
    endtask

    task automatic read_tests();
        int    fd;
        int    total;
        string line;
        string k;
        fd = $fopen("tb/uart_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/uart_tests.txt");
            tb_errs++;
            return;
        end
        void'($fgets(line, fd)); // two header lines
        void'($fgets(line, fd));
        total = 0;
        while (n_tests < MAX_TESTS && $fscanf(fd, "%s %s %h %d", k, t_name[n_tests],
                                               t_opt[n_tests], t_n[n_tests]) == 4) begin
            t_kind[n_tests] = k;
            for (int j = 0; j < t_n[n_tests]; j++)
                void'($fscanf(fd, "%h", t_val[n_tests][j]));
            if (k == "rx")
                total += t_n[n_tests];
            else if (k == "log")
                total += 6 * t_n[n_tests];
            else if (k == "bad")
                n_bad++;
            n_tests++;
        end
        $fclose(fd);
        limit = total * 10 * CLKS_PER_BIT * 3 + 2000;
    endtask

    initial begin
        int total_errs;
        arst_n      = 1'b0;
        rx          = 1'b1;
        log_valid   = 1'b0;
        log_value   = '0;
        push        = 1'b0;
        push_byte   = '0;
        push_name   = '0;
        expect_busy = 1'b0;
        read_tests();
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (100) @(posedge clk); // reset state watched by the monitor
        #1;
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        wait_drain();
        repeat (20 * CLKS_PER_BIT) @(posedge clk); // catch stray bytes
        if (pending != 0) begin
            $display("%0d expected bytes never appeared on tx", pending);
            tb_errs++;
        end
        if (fe_count != n_bad) begin
            $display("saw %0d frame errors for %0d bad frames", fe_count, n_bad);
            tb_errs++;
        end
        total_errs = value_errs + other_errs + tb_errs;
        $display("errors: %0d value, %0d monitor, %0d testbench, %0d total",
                 value_errs, other_errs, tb_errs, total_errs);
        if (total_errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb/uart_monitor.sv
`timescale 1ns/10ps
module uart_monitor (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            tx,
    input  logic            frame_error,
    input  logic            log_ready,
    input  logic            expect_busy,  // logger must be mid message
    input  logic            push,
    input  uart_pkg::byte_t push_byte,
    input  logic [127:0]    push_name,
    output int              pending,
    output int              value_errs,
    output int              other_errs,
    output int              fe_count
);
    import uart_pkg::*;

    byte_t        exp_q[$];
    logic [127:0] name_q[$];
    int           post_cnt = 0;

    initial begin
        pending    = 0;
        value_errs = 0;
        other_errs = 0;
        fe_count   = 0;
    end

    always @(posedge clk) begin
        if (push) begin
            exp_q.push_back(push_byte);
            name_q.push_back(push_name);
            pending = exp_q.size();
        end
        if (arst_n && frame_error)
            fe_count++;
        if (expect_busy && log_ready !== 1'b0) begin
            $display("log_ready high while a message is still being sent");
            other_errs++;
        end
    end

    // reset values sampled half a cycle away from the active edge
    always @(negedge clk) begin
        if (!arst_n || post_cnt < 100) begin // reset state window
            if (tx !== 1'b1 || log_ready !== 1'b1 || frame_error !== 1'b0) begin
                $display("reset state wrong: tx=%b log_ready=%b frame_error=%b",
                         tx, log_ready, frame_error);
                other_errs++;
            end
        end
        if (arst_n && post_cnt < 100)
            post_cnt++;
    end

    task automatic decode_frame();
        byte_t        got;
        byte_t        want;
        logic [127:0] nm;
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        if (tx !== 1'b0) begin
            $display("tx start bit did not hold to its center");
            other_errs++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            got[i] = tx; // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        if (tx !== 1'b1) begin
            $display("tx stop bit low after byte %h", got);
            other_errs++;
        end
        if (exp_q.size() == 0) begin
            $display("extra byte %h on tx with nothing expected", got);
            other_errs++;
        end else begin
            want    = exp_q.pop_front();
            nm      = name_q.pop_front();
            pending = exp_q.size();
            if (got !== want) begin
                $display("Error %0s: expected %h, actual %h", nm, want, got);
                value_errs++;
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge tx);
            if (arst_n)
                decode_frame();
        end
    end

endmodule

//--- verilog/uart_echo_top.sv
`timescale 1ns/10ps
module uart_echo_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rx,
    input  logic               log_valid,
    input  uart_pkg::log_val_t log_value,
    output logic               log_ready,
    output logic               tx,
    output logic               frame_error
);
    import uart_pkg::*;

    logic  rx_valid;
    byte_t rx_byte;

    byte_t echo_byte;
    logic  echo_valid;
    logic  echo_ready;

    logic  hex_valid;
    byte_t hex_byte;
    logic  hex_ready;

    logic  log_sel;
    logic  wr_valid;
    byte_t wr_data;
    logic  wr_ready;

    logic  rd_valid;
    byte_t rd_data;
    logic  rd_ready;

    uart_rx u_rx (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .frame_error (frame_error)
    );

    uart_hex_logger u_logger (
        .clk       (clk),
        .arst_n    (arst_n),
        .log_valid (log_valid),
        .log_value (log_value),
        .log_ready (log_ready),
        .hex_valid (hex_valid),
        .hex_byte  (hex_byte),
        .hex_ready (hex_ready)
    );

    // echo holding register, the receiver cannot be stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            echo_valid <= 1'b0;
        else if (rx_valid)
            echo_valid <= 1'b1;
        else if (echo_ready)
            echo_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rx_valid)
            echo_byte <= rx_byte;
    end

    // the logger holds hex_valid for its whole message, so this keeps
    // the write port until the line feed is written
    assign log_sel = hex_valid;

    assign wr_valid   = log_sel ? hex_valid : echo_valid;
    assign wr_data    = log_sel ? hex_byte  : echo_byte;
    assign hex_ready  = log_sel && wr_ready;
    assign echo_ready = !log_sel && echo_valid && wr_ready;

    byte_fifo #(
        .depth (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_ready (wr_ready),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_ready (rd_ready)
    );

    uart_tx u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (rd_valid),
        .in_byte  (rd_data),
        .in_ready (rd_ready),
        .tx       (tx)
    );

endmodule

//--- verilog/uart_hex_logger.sv
`timescale 1ns/10ps
module uart_hex_logger (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               log_valid,
    input  uart_pkg::log_val_t log_value,
    output logic               log_ready,
    output logic               hex_valid,
    output uart_pkg::byte_t    hex_byte,
    input  logic               hex_ready
);
    import uart_pkg::*;

    log_state_t state;
    log_val_t   value;
    logic [2:0] idx;    // character position in the message
    logic [3:0] nibble;

    // 0-9 -> '0'-'9', 10-15 -> 'A'-'F'
    function automatic byte_t to_ascii(input logic [3:0] nib);
        if (nib < 4'd10)
            return 8'h30 + byte_t'(nib);
        else
            return 8'h37 + byte_t'(nib);
    endfunction

    assign log_ready = (state == LOG_IDLE);
    assign hex_valid = (state == LOG_SEND);

    always_comb begin
        case (idx)
            3'd0:    nibble = value[15:12]; // most significant digit first
            3'd1:    nibble = value[11:8];
            3'd2:    nibble = value[7:4];
            default: nibble = value[3:0];
        endcase
    end

    always_comb begin
        case (idx)
            3'd4:    hex_byte = ASCII_CR;
            3'd5:    hex_byte = ASCII_LF;
            default: hex_byte = to_ascii(nibble);
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= LOG_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                LOG_IDLE: begin
                    if (log_valid) begin
                        state <= LOG_SEND;
                        idx   <= '0;
                    end
                end
                LOG_SEND: begin
                    if (hex_ready) begin
                        if (idx == 3'(LOG_LAST_IDX))
                            state <= LOG_IDLE; // whole message out, take next request
                        else
                            idx <= idx + 1'b1;
                    end
                end
                default: state <= LOG_IDLE;
            endcase
        end
    end

    // value held for the whole message
    always_ff @(posedge clk) begin
        if (state == LOG_IDLE && log_valid)
            value <= log_value;
    end

endmodule

//--- verilog/byte_fifo.sv
`timescale 1ns/10ps
module byte_fifo #(
    parameter int depth = uart_pkg::FIFO_DEPTH
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wr_valid,
    input  uart_pkg::byte_t wr_data,
    output logic            wr_ready,
    output logic            rd_valid,
    output uart_pkg::byte_t rd_data,
    input  logic            rd_ready
);
    import uart_pkg::*;

    localparam int PTR_W = $clog2(depth);
    localparam int CNT_W = $clog2(depth + 1);

    byte_t            mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    wire do_wr = wr_valid && wr_ready;
    wire do_rd = rd_valid && rd_ready;

    // full blocks writes even when a read happens in the same cycle
    assign wr_ready = (count != CNT_W'(depth));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/10ps
module uart_tx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  uart_pkg::byte_t in_byte,
    output logic            in_ready,
    output logic            tx
);
    import uart_pkg::*;

    tx_state_t state;
    bit_cnt_t  cnt;
    bit_idx_t  bit_idx;
    byte_t     shift;
    logic      tx_q;

    wire bit_done = (cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

    assign in_ready = (state == TX_IDLE);
    assign tx       = tx_q; // straight from a flop, no glitches

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_q    <= 1'b1;
        end else begin
            cnt <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (in_valid) begin
                        state <= TX_START;
                        tx_q  <= 1'b0; // start bit
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx_q    <= shift[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx_q  <= 1'b1;
                        end else begin
                            tx_q <= shift[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // payload shifter, next bit always sits in shift[0]
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && in_valid)
            shift <= in_byte;
        else if ((state == TX_START || state == TX_DATA) && bit_done)
            shift <= {1'b0, shift[7:1]};
    end

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/10ps
module uart_rx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rx,
    output logic            rx_valid,
    output uart_pkg::byte_t rx_byte,
    output logic            frame_error
);
    import uart_pkg::*;

    logic      rx_meta;
    logic      rx_sync;
    logic      rx_prev;
    rx_state_t state;
    bit_cnt_t  cnt;
    bit_idx_t  bit_idx;
    byte_t     shift;

    // two flop synchronizer plus one more stage for edge detect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0; // both are single cycle pulses
            frame_error <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin // falling edge of start bit
                        state <= RX_START;
                        cnt   <= '0;
                    end
                end
                RX_START: begin
                    if (cnt == bit_cnt_t'(HALF_BIT - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch filter, start bit must still be low at its center
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        cnt         <= '0;
                        state       <= RX_IDLE;
                        rx_valid    <= rx_sync;
                        frame_error <= !rx_sync; // stop bit low, drop the byte
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data shift register, lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == bit_cnt_t'(CLKS_PER_BIT - 1))
            shift <= {rx_sync, shift[7:1]};
    end

    assign rx_byte = shift;

endmodule

//--- verilog/uart_pkg.sv
package uart_pkg;

    // serial timing, kept short for simulation
    localparam int CLKS_PER_BIT = 16;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    localparam int FIFO_DEPTH = 16; // transmit fifo entries

    typedef logic [7:0]           byte_t;
    typedef logic [15:0]          log_val_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;   // clocks within one bit time
    typedef logic [2:0]           bit_idx_t;   // data bit position 0..7

    // logger message is four hex digits then cr, lf
    localparam byte_t ASCII_CR     = 8'h0d;
    localparam byte_t ASCII_LF     = 8'h0a;
    localparam int    LOG_LAST_IDX = 5;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic {
        LOG_IDLE,
        LOG_SEND
    } log_state_t;

endpackage
